// ==== source/mips_pkg.sv ====
package mips_pkg;

    localparam int WORD_W = 32;

    localparam logic [WORD_W-1:0] RESET_VECTOR = 32'hBFC0_0000;
    localparam logic [4:0] REG_RA = 5'd31;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // Function field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // Internal instruction codes, NOP for anything not recognised
    typedef enum logic [6:0] {
        NOP   = 7'd0,
        ADDIU = 7'd3,
        ADDU  = 7'd4,
        AND   = 7'd5,
        ANDI  = 7'd6,
        OR    = 7'd15,
        ORI   = 7'd16,
        SLL   = 7'd17,
        SLT   = 7'd19,
        SLTU  = 7'd22,
        SRA   = 7'd23,
        SRL   = 7'd25,
        SUBU  = 7'd27,
        XOR   = 7'd28,
        XORI  = 7'd29,
        BEQ   = 7'd30,
        BNE   = 7'd37,
        J     = 7'd38,
        JAL   = 7'd39,
        JR    = 7'd41,
        LUI   = 7'd46,
        LW    = 7'd47,
        SW    = 7'd52
    } instruction_t;

    // Low half is either rd/shamt/funct or a 16-bit immediate
    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_tail_t;

    typedef union packed {
        r_tail_t     r;
        logic [15:0] imm16;
    } ri_tail_t;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        ri_tail_t   tail;
    } ri_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] target;
    } j_view_t;

    typedef union packed {
        ri_view_t ri;
        j_view_t  j;
    } instr_word_t;

endpackage

// ==== source/mips_state_machine.sv ====
`timescale 1ns/100ps

module mips_state_machine (
    input  logic clk,
    input  logic arst_n,
    input  logic stall,
    input  logic halt,
    output logic fetch,
    output logic exec1,
    output logic exec2
);

    // One-hot ring, bit 0 is fetch
    logic [2:0] ring;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ring <= 3'b001;
        end else if (!stall && !halt) begin
            ring <= {ring[1:0], ring[2]};
        end
    end

    // All enables drop once halted
    always_comb begin
        fetch = ring[0] && !halt;
        exec1 = ring[1] && !halt;
        exec2 = ring[2] && !halt;
    end

endmodule

// ==== source/mips_ir_decode.sv ====
`timescale 1ns/100ps

module mips_ir_decode (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch,
    input  logic                        exec1,
    input  logic                        load,
    input  logic [mips_pkg::WORD_W-1:0] instr_in,
    output mips_pkg::instruction_t      instruction_code,
    output logic [4:0]                  reg_a_idx,
    output logic [4:0]                  reg_b_idx,
    output logic [4:0]                  dest_idx,
    output logic [4:0]                  shift_amount,
    output logic [mips_pkg::WORD_W-1:0] immediate,
    output logic [25:0]                 jump_target,
    output logic                        reg_write_en,
    output logic                        use_imm
);

    import mips_pkg::*;

    instr_word_t ir;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (fetch && load) begin
            ir <= instr_in;
        end
    end

    // Opcode and funct to internal code
    always_comb begin
        instruction_code = NOP;
        case (ir.ri.opcode)
            OP_SPECIAL: begin
                case (ir.ri.tail.r.funct)
                    FN_ADDU: instruction_code = ADDU;
                    FN_SUBU: instruction_code = SUBU;
                    FN_AND:  instruction_code = AND;
                    FN_OR:   instruction_code = OR;
                    FN_XOR:  instruction_code = XOR;
                    FN_SLT:  instruction_code = SLT;
                    FN_SLTU: instruction_code = SLTU;
                    FN_SLL:  instruction_code = SLL;
                    FN_SRL:  instruction_code = SRL;
                    FN_SRA:  instruction_code = SRA;
                    FN_JR:   instruction_code = JR;
                    default: instruction_code = NOP;
                endcase
            end
            OP_ADDIU: instruction_code = ADDIU;
            OP_ANDI:  instruction_code = ANDI;
            OP_ORI:   instruction_code = ORI;
            OP_XORI:  instruction_code = XORI;
            OP_LUI:   instruction_code = LUI;
            OP_LW:    instruction_code = LW;
            OP_SW:    instruction_code = SW;
            OP_BEQ:   instruction_code = BEQ;
            OP_BNE:   instruction_code = BNE;
            OP_J:     instruction_code = J;
            OP_JAL:   instruction_code = JAL;
            default:  instruction_code = NOP;
        endcase
    end

    always_comb begin
        reg_a_idx    = ir.ri.rs;
        reg_b_idx    = ir.ri.rt;
        shift_amount = ir.ri.tail.r.shamt;
        jump_target  = ir.j.target;

        // Logical immediates are zero-extended, JAL adds 4 to the PC
        case (instruction_code)
            ANDI, ORI, XORI: immediate = {16'h0000, ir.ri.tail.imm16};
            LUI:             immediate = {ir.ri.tail.imm16, 16'h0000};
            JAL:             immediate = 32'd4;
            default:         immediate = {{16{ir.ri.tail.imm16[15]}}, ir.ri.tail.imm16};
        endcase

        if (instruction_code == JAL) begin
            dest_idx = REG_RA;
        end else if (ir.ri.opcode == OP_SPECIAL) begin
            dest_idx = ir.ri.tail.r.rd;
        end else begin
            dest_idx = ir.ri.rt;
        end

        case (instruction_code)
            SW, BEQ, BNE, J, JR, NOP: reg_write_en = 1'b0;
            default:                  reg_write_en = 1'b1;
        endcase

        // Address offset only matters while the transfer runs
        case (instruction_code)
            ADDIU, ANDI, ORI, XORI, LUI, JAL: use_imm = 1'b1;
            LW, SW:                           use_imm = exec1;
            default:                          use_imm = 1'b0;
        endcase
    end

endmodule

// ==== source/mips_alu.sv ====
`timescale 1ns/100ps

module mips_alu (
    input  logic [mips_pkg::WORD_W-1:0] a,
    input  logic [mips_pkg::WORD_W-1:0] b,
    input  mips_pkg::instruction_t      op,
    input  logic [4:0]                  sa,
    output logic [mips_pkg::WORD_W-1:0] r,
    output logic                        zero
);

    import mips_pkg::*;

    always_comb begin
        case (op)
            // Address and link calculations share the adder
            ADDU, ADDIU, LW, SW, JAL: begin
                r = a + b;
            end
            SUBU, BEQ, BNE: begin
                r = a - b;
            end
            AND, ANDI: begin
                r = a & b;
            end
            OR, ORI: begin
                r = a | b;
            end
            XOR, XORI: begin
                r = a ^ b;
            end
            SLT: begin
                r = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(b)};
            end
            SLTU: begin
                r = {{(WORD_W-1){1'b0}}, a < b};
            end
            // Shifts act on rt
            SLL: begin
                r = b << sa;
            end
            SRL: begin
                r = b >> sa;
            end
            SRA: begin
                r = $signed(b) >>> sa;
            end
            LUI: begin
                r = b;
            end
            default: begin
                r = a;
            end
        endcase
    end

    assign zero = (r == '0);

endmodule

// ==== source/mips_register_file.sv ====
`timescale 1ns/100ps

module mips_register_file (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        write_enable,
    input  logic [4:0]                  register_a_index,
    input  logic [4:0]                  register_b_index,
    input  logic [4:0]                  write_register,
    input  logic [mips_pkg::WORD_W-1:0] write_data,
    output logic [mips_pkg::WORD_W-1:0] register_a_data,
    output logic [mips_pkg::WORD_W-1:0] register_b_data,
    output logic [mips_pkg::WORD_W-1:0] v0
);

    import mips_pkg::*;

    logic [WORD_W-1:0] regs [32];

    // Register 0 is never written, so it reads as zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_register != 5'd0) begin
            regs[write_register] <= write_data;
        end
    end

    assign register_a_data = regs[register_a_index];
    assign register_b_data = regs[register_b_index];
    assign v0 = regs[2];

endmodule

// ==== source/mips_pc.sv ====
`timescale 1ns/100ps

module mips_pc (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        exec2,
    input  logic                        stall,
    input  mips_pkg::instruction_t      internal_code,
    input  logic [15:0]                 offset,
    input  logic [25:0]                 instr_index,
    input  logic [mips_pkg::WORD_W-1:0] register_data,
    input  logic                        zero,
    output logic [mips_pkg::WORD_W-1:0] address,
    output logic                        pc_halt
);

    import mips_pkg::*;

    logic [WORD_W-1:0] pc_plus4, branch_target, jump_target, pc_next;

    assign pc_plus4 = address + 32'd4;
    assign branch_target = pc_plus4 + {{14{offset[15]}}, offset, 2'b00};
    assign jump_target = {pc_plus4[31:28], instr_index, 2'b00};

    // No delay slot, taken targets apply at once
    always_comb begin
        pc_next = pc_plus4;
        case (internal_code)
            BEQ:     if (zero) pc_next = branch_target;
            BNE:     if (!zero) pc_next = branch_target;
            J, JAL:  pc_next = jump_target;
            JR:      pc_next = register_data;
            default: pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            address <= RESET_VECTOR;
            pc_halt <= 1'b0;
        end else if (exec2 && !stall && !pc_halt) begin
            address <= pc_next;
            // JR to zero ends the program, held until reset
            if (internal_code == JR && register_data == '0) begin
                pc_halt <= 1'b1;
            end
        end
    end

endmodule

// ==== source/mips_mem_unit.sv ====
`timescale 1ns/100ps

module mips_mem_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        fetch,
    input  logic                        exec1,
    input  logic                        halt,
    input  mips_pkg::instruction_t      instruction_code,
    input  logic [mips_pkg::WORD_W-1:0] pc_address,
    input  logic [mips_pkg::WORD_W-1:0] alu_r,
    input  logic [mips_pkg::WORD_W-1:0] reg_b_data,
    input  logic [mips_pkg::WORD_W-1:0] readdata,
    input  logic                        waitrequest,
    output logic [mips_pkg::WORD_W-1:0] mem_address,
    output logic                        read,
    output logic                        write,
    output logic [mips_pkg::WORD_W-1:0] writedata,
    output logic [mips_pkg::WORD_W-1:0] load_data,
    output logic                        instr_load,
    output logic                        mem_stall
);

    import mips_pkg::*;

    logic is_lw, is_sw;

    assign is_lw = (instruction_code == LW);
    assign is_sw = (instruction_code == SW);

    // Fetch uses the PC, data transfers use the ALU address
    always_comb begin
        mem_address = exec1 ? alu_r : pc_address;
        read        = !halt && (fetch || (exec1 && is_lw));
        write       = !halt && exec1 && is_sw;
        writedata   = reg_b_data;
    end

    // Held request keeps the sequencer in place
    assign mem_stall = (read || write) && waitrequest;

    assign instr_load = fetch && !halt && !waitrequest;

    // Load word captured in the completing cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            load_data <= '0;
        end else if (read && exec1 && !waitrequest) begin
            load_data <= readdata;
        end
    end

endmodule

// ==== source/mips_cpu_bus.sv ====
`timescale 1ns/100ps

module mips_cpu_bus (
    input  logic                        clk,
    input  logic                        arst_n,
    output logic                        active,
    output logic [mips_pkg::WORD_W-1:0] register_v0,

    // Avalon master, shared by instruction and data
    output logic [mips_pkg::WORD_W-1:0] address,
    output logic                        write,
    output logic                        read,
    input  logic                        waitrequest,
    output logic [mips_pkg::WORD_W-1:0] writedata,
    output logic [3:0]                  byteenable,
    input  logic [mips_pkg::WORD_W-1:0] readdata
);

    import mips_pkg::*;

    logic fetch, exec1, exec2;
    logic mem_stall, pc_halt, instr_load;
    logic reg_write_en, use_imm, zero;
    instruction_t instruction_code;
    logic [4:0] reg_a_idx, reg_b_idx, dest_idx, shift_amount;
    logic [25:0] jump_target;
    logic [WORD_W-1:0] immediate, reg_a_data, reg_b_data;
    logic [WORD_W-1:0] alu_r, pc_address, load_data;

    // Word transfers only
    assign byteenable = 4'b1111;
    assign active = ~pc_halt;

    mips_state_machine sm (
        .clk(clk), .arst_n(arst_n), .stall(mem_stall), .halt(pc_halt),
        .fetch(fetch), .exec1(exec1), .exec2(exec2)
    );

    mips_ir_decode ir (
        .clk(clk), .arst_n(arst_n), .fetch(fetch), .exec1(exec1),
        .load(instr_load), .instr_in(readdata),
        .instruction_code(instruction_code),
        .reg_a_idx(reg_a_idx), .reg_b_idx(reg_b_idx), .dest_idx(dest_idx),
        .shift_amount(shift_amount), .immediate(immediate),
        .jump_target(jump_target), .reg_write_en(reg_write_en), .use_imm(use_imm)
    );

    // JAL forms its link value from the PC of the instruction
    mips_alu alu (
        .a((instruction_code == JAL) ? pc_address : reg_a_data),
        .b(use_imm ? immediate : reg_b_data),
        .op(instruction_code), .sa(shift_amount), .r(alu_r), .zero(zero)
    );

    mips_register_file regfile (
        .clk(clk), .arst_n(arst_n),
        .write_enable(reg_write_en && exec2 && !mem_stall),
        .register_a_index(reg_a_idx), .register_b_index(reg_b_idx),
        .write_register(dest_idx),
        .write_data((instruction_code == LW) ? load_data : alu_r),
        .register_a_data(reg_a_data), .register_b_data(reg_b_data),
        .v0(register_v0)
    );

    mips_pc pc (
        .clk(clk), .arst_n(arst_n), .exec2(exec2), .stall(mem_stall),
        .internal_code(instruction_code), .offset(immediate[15:0]),
        .instr_index(jump_target), .register_data(reg_a_data), .zero(zero),
        .address(pc_address), .pc_halt(pc_halt)
    );

    mips_mem_unit mxu (
        .clk(clk), .arst_n(arst_n), .fetch(fetch), .exec1(exec1), .halt(pc_halt),
        .instruction_code(instruction_code), .pc_address(pc_address),
        .alu_r(alu_r), .reg_b_data(reg_b_data), .readdata(readdata),
        .waitrequest(waitrequest), .mem_address(address), .read(read),
        .write(write), .writedata(writedata), .load_data(load_data),
        .instr_load(instr_load), .mem_stall(mem_stall)
    );

endmodule

// ==== bench/mips_cpu_bus_assertions.sv ====
`timescale 1ns/100ps

module mips_cpu_bus_assertions (
    input logic        clk,
    input logic        arst_n,
    input logic        read,
    input logic        write,
    input logic        waitrequest,
    input logic        active,
    input logic [31:0] address
);

    a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n)
        !(read && write)) else $error("read and write high together");

    a_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        (read || write) |-> address[1:0] == 2'b00) else $error("unaligned bus address");

    // Request held until waitrequest drops
    a_held: assert property (@(posedge clk) disable iff (!arst_n)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("bus request changed under waitrequest");

    a_halted: assert property (@(posedge clk) disable iff (!arst_n)
        !active |=> !active) else $error("active rose again without reset");

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions bus_chk (
    .clk(clk), .arst_n(arst_n), .read(read), .write(write),
    .waitrequest(waitrequest), .active(active), .address(address)
);

// ==== bench/mips_cpu_bus_tb.sv ====
`timescale 1ns/100ps

module mips_cpu_bus_tb;

    import mips_pkg::*;

    localparam int watchdog_ns = 6 * 400 * 3 * 3 * 8;

    logic clk, arst_n, active, write, read, waitrequest;
    logic [WORD_W-1:0] register_v0, address, writedata, readdata;
    logic [3:0] byteenable;
    logic [WORD_W-1:0] prog [256];
    logic [WORD_W-1:0] data_mem [64];
    int prog_len, mismatches, other_errors, wait_left;
    bit busy, in_reset;
    integer seed = 32'h2e96_2cd6;

    mips_cpu_bus UUT (
        .clk(clk), .arst_n(arst_n), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rtype(logic [4:0] rs, rt, rd, sa, logic [5:0] fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] itype(logic [5:0] op, logic [4:0] rs, rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Word index within the program region to a J-format word
    function automatic logic [31:0] jtype(logic [5:0] op, int idx);
        logic [31:0] target;
        target = RESET_VECTOR + 32'(idx * 4);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] mem_read(logic [31:0] addr);
        if (addr[31:10] == RESET_VECTOR[31:10]) return prog[addr[9:2]];
        if (addr[31:8] == 24'h000010) return data_mem[addr[7:2]];
        return 32'h0;
    endfunction

    // Avalon slave with one or two waitrequest cycles per transfer
    always @(posedge clk) begin
        in_reset = !arst_n;
        if (!in_reset && busy && !waitrequest) begin
            check_byteenable(byteenable);
            if (write && address[31:8] == 24'h000010) begin
                data_mem[address[7:2]] = writedata;
            end else if (write) begin
                other_errors++;
                $display("Write outside the data region at %h", address);
            end
            busy = 1'b0;
        end
        #1;
        if (in_reset) begin
            busy = 1'b0;
            waitrequest = 1'b1;
        end else if (busy) begin
            wait_left--;
            if (wait_left == 0) begin
                readdata = mem_read(address);
                waitrequest = 1'b0;
            end
        end else if (read || write) begin
            busy = 1'b1;
            wait_left = 1 + ($random(seed) & 1);
            waitrequest = 1'b1;
        end
    end

    task automatic emit(logic [31:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // Appends JR $0, resets the core and runs it to the halt
    task automatic run_program();
        emit(rtype(0, 0, 0, 0, FN_JR));
        @(posedge clk);
        #1 arst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        @(posedge clk);
        while (active) @(negedge clk);
        prog_len = 0;
    endtask

    task automatic check_v0(logic [WORD_W-1:0] expected, string what);
        if (register_v0 !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: %s v0 expected %h got %h", $time, what, expected,
                     register_v0);
        end
    endtask

    task automatic check_mem(logic [31:0] addr, logic [WORD_W-1:0] expected);
        if (data_mem[addr[7:2]] !== expected) begin
            mismatches++;
            $display("MISMATCH at %0t: word at %h expected %h got %h", $time, addr, expected,
                     data_mem[addr[7:2]]);
        end
    endtask

    // Word transfers only, so every byte lane is enabled
    task automatic check_byteenable(logic [3:0] value);
        if (value !== 4'b1111) begin
            mismatches++;
            $display("MISMATCH at %0t: byteenable expected 1111 got %b", $time, value);
        end
    endtask

    task automatic fold(logic [31:0] w);
        emit(w);
        emit(rtype(2, 11, 2, 0, FN_XOR));
    endtask

    task automatic alu_immediates();
        emit(itype(OP_ADDIU, 0, 2, 16'h1234));
        emit(itype(OP_ORI, 2, 2, 16'hF0F0));
        emit(itype(OP_ANDI, 2, 2, 16'h0FF0));
        emit(itype(OP_XORI, 2, 2, 16'hAAAA));
        emit(itype(OP_LUI, 0, 3, 16'h8001));
        emit(rtype(2, 3, 2, 0, FN_ADDU));
        emit(itype(OP_ADDIU, 2, 2, 16'hFFFB));
        run_program();
        check_v0((((32'h1234 | 32'hF0F0) & 32'h0FF0) ^ 32'hAAAA) + 32'h8001_0000 - 5,
                 "immediates");
    endtask

    task automatic register_alu();
        logic [31:0] a, b, e;
        a = 32'h8765_4321;
        b = 32'h1234_0F0F;
        e = (a + b) ^ (a - b) ^ (a & b) ^ (a | b) ^ (a ^ b) ^ 32'd1 ^ (a << 4) ^ (a >> 7);
        e = e ^ {{7{a[31]}}, a[31:7]};
        emit(itype(OP_LUI, 0, 8, 16'h8765));
        emit(itype(OP_ORI, 8, 8, 16'h4321));
        emit(itype(OP_LUI, 0, 9, 16'h1234));
        emit(itype(OP_ORI, 9, 9, 16'h0F0F));
        fold(rtype(8, 9, 11, 0, FN_ADDU));
        fold(rtype(8, 9, 11, 0, FN_SUBU));
        fold(rtype(8, 9, 11, 0, FN_AND));
        fold(rtype(8, 9, 11, 0, FN_OR));
        fold(rtype(8, 9, 11, 0, FN_XOR));
        // a is negative, so only the signed compare sets
        fold(rtype(8, 9, 11, 0, FN_SLT));
        fold(rtype(8, 9, 11, 0, FN_SLTU));
        fold(rtype(0, 8, 11, 4, FN_SLL));
        fold(rtype(0, 8, 11, 7, FN_SRL));
        fold(rtype(0, 8, 11, 7, FN_SRA));
        run_program();
        check_v0(e, "register fold");
    endtask

    task automatic memory_roundtrip();
        emit(itype(OP_ADDIU, 0, 4, 16'h1000));
        emit(itype(OP_LUI, 0, 5, 16'h1111));
        emit(itype(OP_ORI, 5, 5, 16'h2222));
        emit(rtype(5, 5, 6, 0, FN_ADDU));
        emit(itype(OP_ADDIU, 4, 14, 16'h0010));
        emit(itype(OP_SW, 4, 5, 16'h0000));
        emit(itype(OP_SW, 4, 6, 16'h0004));
        emit(itype(OP_SW, 14, 6, 16'hFFFC));
        emit(itype(OP_LW, 4, 7, 16'h0000));
        emit(itype(OP_LW, 4, 12, 16'h0004));
        emit(itype(OP_LW, 4, 13, 16'h000C));
        emit(rtype(7, 12, 2, 0, FN_ADDU));
        emit(rtype(2, 13, 2, 0, FN_ADDU));
        run_program();
        check_mem(32'h1000, 32'h1111_2222);
        check_mem(32'h1004, 32'h2222_4444);
        check_mem(32'h100C, 32'h2222_4444);
        check_v0(32'h1111_2222 + 32'h2222_4444 * 2, "load sum");
    endtask

    task automatic branches();
        emit(itype(OP_ADDIU, 0, 8, 16'd5));
        emit(itype(OP_ADDIU, 0, 9, 16'd5));
        emit(itype(OP_ADDIU, 0, 10, 16'd6));
        emit(itype(OP_ADDIU, 0, 11, 16'd3));
        emit(itype(OP_BEQ, 8, 9, 16'd1));
        emit(itype(OP_ADDIU, 2, 2, 16'd1));
        emit(itype(OP_ADDIU, 2, 2, 16'd2));
        emit(itype(OP_BEQ, 8, 10, 16'd1));
        emit(itype(OP_ADDIU, 2, 2, 16'd4));
        emit(itype(OP_BNE, 8, 10, 16'd1));
        emit(itype(OP_ADDIU, 2, 2, 16'd8));
        emit(itype(OP_BNE, 8, 9, 16'd1));
        emit(itype(OP_ADDIU, 2, 2, 16'd16));
        // Backward loop of three passes
        emit(itype(OP_ADDIU, 2, 2, 16'd128));
        emit(itype(OP_ADDIU, 11, 11, 16'hFFFF));
        emit(itype(OP_BNE, 11, 0, 16'hFFFD));
        emit(itype(OP_ADDIU, 2, 2, 16'd64));
        run_program();
        check_v0(32'd2 + 32'd4 + 32'd16 + 32'd64 + 32'd3 * 32'd128, "branch paths");
    endtask

    task automatic jumps();
        emit(itype(OP_ADDIU, 0, 2, 16'd1));
        emit(jtype(OP_J, 3));
        emit(itype(OP_ADDIU, 2, 2, 16'd2));
        emit(jtype(OP_JAL, 7));
        emit(rtype(2, 31, 2, 0, FN_ADDU));
        emit(rtype(0, 0, 0, 0, FN_JR));
        emit(itype(OP_ADDIU, 2, 2, 16'd8));
        emit(itype(OP_ADDIU, 2, 2, 16'd16));
        emit(rtype(31, 0, 0, 0, FN_JR));
        run_program();
        // Link is the JAL address plus 4
        check_v0(32'd17 + RESET_VECTOR + 32'd16, "jump and link");
    endtask

    task automatic register_zero();
        emit(itype(OP_ADDIU, 0, 2, 16'h0099));
        emit(itype(OP_ADDIU, 0, 0, 16'h0055));
        emit(itype(OP_ORI, 0, 0, 16'h0077));
        emit(rtype(0, 0, 2, 0, FN_ADDU));
        run_program();
        check_v0(32'h0, "register zero");
    endtask

    initial begin
        #watchdog_ns;
        $display("Timeout: the DUT did not halt within %0d ns", watchdog_ns);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        arst_n = 1'b0;
        waitrequest = 1'b1;
        readdata = '0;
        prog_len = 0;
        for (int i = 0; i < 256; i++) prog[i] = 32'h0;
        for (int i = 0; i < 64; i++) data_mem[i] = 32'h0;
        alu_immediates();
        register_alu();
        memory_roundtrip();
        branches();
        jumps();
        register_zero();
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
source/mips_pkg.sv
source/mips_state_machine.sv
source/mips_ir_decode.sv
source/mips_alu.sv
source/mips_register_file.sv
source/mips_pc.sv
source/mips_mem_unit.sv
source/mips_cpu_bus.sv
bench/mips_cpu_bus_assertions.sv
bench/mips_cpu_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module mips_cpu_bus_tb \
    -f tb.f -o mips_cpu_bus_sim
out=$(./obj_dir/mips_cpu_bus_sim)
echo "$out"
echo "$out" | grep -q "Simulation completed successfully"
